//--- flist.f
+incdir+tb
source/mdu_pkg.sv
source/mdu_ctrl.sv
source/mdu_iter_counter.sv
source/mdu_multiplier.sv
source/mdu_divider.sv
source/mdu_top.sv
tb/mdu_clk_gen.sv
tb/mdu_tb.sv

//--- source/mdu_ctrl.sv
/*
 * Control FSM of the multiply/divide unit
 * Sequences capture, divider setup, iteration and completion
 * Owns ready and the clock request
 */
`timescale 1ns/1ns
`default_nettype none

module mdu_ctrl
    import mdu_pkg::*;
(
    input  wire             g_clk,
    input  wire             rst_n,
    input  wire             flush,
    input  wire             valid,
    input  wire mdu_op_e    op,
    input  wire             last,
    output mdu_state_e      state,
    output logic            is_mul,
    output logic            capture,
    output logic            div_setup,
    output logic            step,
    output logic            ready,
    output logic            g_clk_req
);

    mdu_state_e state_nxt;

    // ------------------------------------------------------------------------
    // Decode and strobes
    // ------------------------------------------------------------------------

    assign is_mul    = op inside {MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU};

    assign capture   = (state == ST_IDLE) && valid;   // Operand load
    assign div_setup = (state == ST_DIV_SETUP);
    assign step      = (state == ST_RUN);              // Level for the whole run

    // Clock is needed while work is pending or being thrown away
    assign g_clk_req = valid || flush;

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (valid) begin
                    state_nxt = is_mul ? ST_RUN : ST_DIV_SETUP;
                end
            end
            ST_DIV_SETUP: begin
                state_nxt = ST_RUN;
            end
            ST_RUN: begin
                if (last) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                // Hold result until the requester lets go
                if (!valid) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // Flush wins over everything in the state and ready flops
    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            state <= ST_IDLE;
            ready <= 1'b0;
        end else begin
            state <= state_nxt;
            ready <= (state_nxt == ST_DONE);
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    ready_only_in_done_a: assert property (
        @(posedge g_clk) disable iff (!rst_n)
        ready |-> (state == ST_DONE)
    );

    capture_only_in_idle_a: assert property (
        @(posedge g_clk) disable iff (!rst_n)
        capture |-> (state == ST_IDLE) && !ready
    );

endmodule

`default_nettype wire

//--- source/mdu_divider.sv
/*
 * Restoring divider, one quotient bit per run cycle
 * Operand sign removal, divisor alignment, quotient and remainder
 * sign fixup and word sign-extension
 */
`timescale 1ns/1ns
`default_nettype none

module mdu_divider
    import mdu_pkg::*;
(
    input  wire                 g_clk,
    input  wire                 rst_n,
    input  wire                 flush,
    input  wire                 capture,
    input  wire                 div_setup,
    input  wire                 step,
    input  wire mdu_op_e        op,
    input  wire                 op_word,
    input  wire [XL:0]          rs1,
    input  wire [XL:0]          rs2,
    input  wire [CTR_W-1:0]     count,
    output logic [XL:0]         div_result
);

    logic [XL:0]     rem_r;      // Dividend, then running remainder
    logic [MLEN-1:0] dvsr;       // Raw rs2 until setup, then aligned divisor
    logic [XL:0]     quo;
    logic            neg_q;      // Quotient negated at the output
    logic            neg_r;      // Remainder negated at the output

    logic            div_op;
    logic            div_signed;
    logic            div_rem;

    logic [XL:0]     a_ext;
    logic [XL:0]     b_ext;
    logic            a_neg;
    logic            b_neg;
    logic [XL:0]     a_mag;
    logic [XL:0]     b_mag;
    logic            b_nz;
    logic [MLEN-1:0] dvsr_init;

    logic            fits;
    logic [XL:0]     res;
    logic [XL:0]     res_s;

    assign div_op     = op inside {MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU};
    assign div_signed = (op == MDU_DIV) || (op == MDU_REM);
    assign div_rem    = (op == MDU_REM) || (op == MDU_REMU);

    // ------------------------------------------------------------------------
    // Setup: operand extension and magnitudes
    // ------------------------------------------------------------------------

    always_comb begin
        if (op_word) begin
            a_ext = {{(XLEN-WLEN){div_signed && rem_r[WLEN-1]}}, rem_r[WLEN-1:0]};
            b_ext = {{(XLEN-WLEN){div_signed && dvsr[WLEN-1]}}, dvsr[WLEN-1:0]};
        end else begin
            a_ext = rem_r;
            b_ext = dvsr[XL:0];
        end
    end

    assign a_neg = div_signed && a_ext[XL];
    assign b_neg = div_signed && b_ext[XL];
    assign a_mag = a_neg ? -a_ext : a_ext;
    assign b_mag = b_neg ? -b_ext : b_ext;
    assign b_nz  = |b_ext;

    // First compare is against divisor shifted to the top quotient bit
    assign dvsr_init = MLEN'(b_mag) << (op_word ? WLEN - 1 : XLEN - 1);

    // ------------------------------------------------------------------------
    // Iteration
    // ------------------------------------------------------------------------

    assign fits = (dvsr <= {{XLEN{1'b0}}, rem_r});

    always_ff @(posedge g_clk) begin
        if (capture && div_op) begin
            rem_r <= rs1;
            dvsr  <= {{XLEN{1'b0}}, rs2};
        end else if (div_setup) begin
            rem_r <= a_mag;
            dvsr  <= dvsr_init;
            quo   <= '0;
        end else if (step && div_op) begin
            if (fits && (count != '0)) begin
                rem_r <= rem_r - dvsr[XL:0];
                quo   <= quo | (XLEN'(1) << (count - CTR_W'(1)));
            end
            dvsr <= dvsr >> 1;
        end
    end

    // Output sign flags
    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            neg_q <= 1'b0;
            neg_r <= 1'b0;
        end else if (div_setup) begin
            neg_q <= (a_neg != b_neg) && b_nz;   // x/0 stays all ones
            neg_r <= a_neg;                      // Follows the dividend
        end
    end

    // ------------------------------------------------------------------------
    // Result
    // ------------------------------------------------------------------------

    assign res   = div_rem ? rem_r : quo;
    assign res_s = (div_rem ? neg_r : neg_q) ? -res : res;

    assign div_result = op_word ? {{(XLEN-WLEN){res_s[WLEN-1]}}, res_s[WLEN-1:0]}
                                : res_s;

    setup_after_capture_a: assert property (
        @(posedge g_clk) disable iff (!rst_n)
        div_setup |-> $past(capture)
    );

endmodule

`default_nettype wire

//--- source/mdu_iter_counter.sv
/*
 * Shared iteration counter for multiply and divide
 * Loaded with the operand width, stepped down per run cycle
 */
`timescale 1ns/1ns
`default_nettype none

module mdu_iter_counter
    import mdu_pkg::*;
(
    input  wire                 g_clk,
    input  wire                 rst_n,
    input  wire                 flush,
    input  wire                 capture,
    input  wire                 op_word,
    input  wire                 is_mul,
    input  wire                 step,
    output logic [CTR_W-1:0]    count,
    output logic                last
);

    logic [CTR_W-1:0] dec;       // Amount taken per step
    logic             mul_last;
    logic             div_last;

    assign dec      = is_mul ? CTR_W'(MUL_UNROLL) : CTR_W'(1);

    // Final multiply step takes the count down to zero
    assign mul_last = (count == CTR_W'(MUL_UNROLL));
    assign div_last = (count == '0);   // Divide spends one run cycle at zero
    assign last     = is_mul ? mul_last : div_last;

    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            count <= '0;
        end else if (capture) begin
            count <= op_word ? CTR_W'(WLEN) : CTR_W'(XLEN);
        end else if (step && (count != '0)) begin
            count <= count - dec;
        end
    end

    // A wrap would show up as a larger count after the step
    no_underflow_a: assert property (
        @(posedge g_clk) disable iff (!rst_n || flush)
        step && (count != '0) |=> (count < $past(count))
    );

endmodule

`default_nettype wire

//--- source/mdu_multiplier.sv
/*
 * Iterative shift-and-add multiplier
 * MUL_UNROLL sign-aware partial products per cycle into a double-width
 * accumulator, result selection for low, high and word forms
 */
`timescale 1ns/1ns
`default_nettype none

module mdu_multiplier
    import mdu_pkg::*;
(
    input  wire             g_clk,
    input  wire             rst_n,
    input  wire             flush,
    input  wire             capture,
    input  wire             step,
    input  wire mdu_op_e    op,
    input  wire             op_word,
    input  wire [XL:0]      rs1,
    input  wire [XL:0]      rs2,
    output logic [XL:0]     mul_result
);

    logic [XL:0]     mcand;      // Multiplicand, held
    logic [XLEN:0]   mplier;     // Multiplier bits plus end marker
    logic [MLEN-1:0] acc;
    logic [MLEN-1:0] acc_nxt;

    logic            mul_op;
    logic            lhs_signed;
    logic            rhs_signed;
    logic            mul_hi;
    logic            final_step;

    logic [XL:0]     pp;
    logic            sub;
    logic [XLEN:0]   add_l;
    logic [XLEN:0]   add_r;
    logic [XLEN:0]   sum;

    assign mul_op     = op inside {MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU};
    assign lhs_signed = (op == MDU_MULH) || (op == MDU_MULHSU);
    assign rhs_signed = (op == MDU_MULH);
    assign mul_hi     = (op != MDU_MUL);

    // Marker sits just above the last group of multiplier bits
    assign final_step = ((mplier >> MUL_UNROLL) == (XLEN+1)'(1));

    // ------------------------------------------------------------------------
    // One run cycle of partial products
    // ------------------------------------------------------------------------

    always_comb begin
        acc_nxt = acc;
        pp      = '0;
        sub     = 1'b0;
        add_l   = '0;
        add_r   = '0;
        sum     = '0;
        for (int i = 0; i < MUL_UNROLL; i++) begin
            pp    = mplier[i] ? mcand : '0;
            // Signed multiplier top bit weighs minus 2^(n-1)
            sub   = final_step && (i == MUL_UNROLL - 1) && rhs_signed && mplier[i];
            add_l = {lhs_signed && acc_nxt[MLEN-1], acc_nxt[MLEN-1:XLEN]};
            add_r = {lhs_signed && pp[XL], pp};
            if (sub) begin
                add_r = ~add_r;
            end
            sum     = add_l + add_r + (XLEN+1)'(sub);
            acc_nxt = {sum, acc_nxt[XL:1]};
        end
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!rst_n || flush) begin
            mplier <= '0;
        end else if (capture && mul_op) begin
            mplier <= op_word ? {(XLEN-WLEN+1)'(1), rs2[WLEN-1:0]} : {1'b1, rs2};
        end else if (step && mul_op) begin
            mplier <= mplier >> MUL_UNROLL;
        end
    end

    always_ff @(posedge g_clk) begin
        if (capture && mul_op) begin
            mcand <= rs1;
            acc   <= '0;
        end else if (step && mul_op) begin
            acc   <= acc_nxt;
        end
    end

    // Word products end up 32 places higher after half the shifts
    always_comb begin
        if (op_word) begin
            mul_result = {{(XLEN-WLEN){acc[XL]}}, acc[XL:WLEN]};
        end else if (mul_hi) begin
            mul_result = acc[MLEN-1:XLEN];
        end else begin
            mul_result = acc[XL:0];
        end
    end

endmodule

`default_nettype wire

//--- source/mdu_pkg.sv
/*
 * Shared definitions for the multiply/divide unit
 * Operand and product widths, unroll factor, counter width
 * Operation enum and control state enum
 */
`default_nettype none

package mdu_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    localparam int XLEN       = 64;          // Operand width
    localparam int XL         = XLEN - 1;    // Top bit index
    localparam int WLEN       = 32;          // Word operand width
    localparam int MLEN       = 2 * XLEN;    // Product and divisor register
    localparam int MUL_UNROLL = 4;           // Partial products per multiply cycle
    localparam int CTR_W      = 7;           // Holds 64

    // ------------------------------------------------------------------------
    // Operations
    // ------------------------------------------------------------------------

    // Multiplies first so bit 2 splits the two classes
    typedef enum logic [2:0] {
        MDU_MUL    = 3'd0,
        MDU_MULH   = 3'd1,
        MDU_MULHSU = 3'd2,
        MDU_MULHU  = 3'd3,
        MDU_DIV    = 3'd4,
        MDU_DIVU   = 3'd5,
        MDU_REM    = 3'd6,
        MDU_REMU   = 3'd7
    } mdu_op_e;

    // Control FSM states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,   // Waiting for valid
        ST_DIV_SETUP = 3'd1,   // Divider operand magnitudes and alignment
        ST_RUN       = 3'd2,   // Iterating
        ST_DONE      = 3'd3    // Result held until valid drops
    } mdu_state_e;

endpackage

`default_nettype wire

//--- source/mdu_top.sv
/*
 * Multiply/divide unit top level
 * Control FSM, iteration counter, both datapaths and the result mux
 */
`timescale 1ns/1ns
`default_nettype none

module mdu_top
    import mdu_pkg::*;
(
    input  wire             g_clk,
    input  wire             rst_n,
    input  wire             flush,
    input  wire             valid,
    input  wire mdu_op_e    op,
    input  wire             op_word,
    input  wire [XL:0]      rs1,
    input  wire [XL:0]      rs2,
    output logic            g_clk_req,
    output logic            ready,
    output logic [XL:0]     rd
);

    mdu_state_e       state;
    logic             is_mul;
    logic             capture;
    logic             div_setup;
    logic             step;
    logic             last;
    logic [CTR_W-1:0] count;
    logic [XL:0]      mul_result;
    logic [XL:0]      div_result;

    mdu_ctrl mdu_ctrl_i (
        .g_clk      (g_clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .valid      (valid),
        .op         (op),
        .last       (last),
        .state      (state),
        .is_mul     (is_mul),
        .capture    (capture),
        .div_setup  (div_setup),
        .step       (step),
        .ready      (ready),
        .g_clk_req  (g_clk_req)
    );

    mdu_iter_counter mdu_iter_counter_i (
        .g_clk      (g_clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .capture    (capture),
        .op_word    (op_word),
        .is_mul     (is_mul),
        .step       (step),
        .count      (count),
        .last       (last)
    );

    mdu_multiplier mdu_multiplier_i (
        .g_clk      (g_clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .capture    (capture),
        .step       (step),
        .op         (op),
        .op_word    (op_word),
        .rs1        (rs1),
        .rs2        (rs2),
        .mul_result (mul_result)
    );

    mdu_divider mdu_divider_i (
        .g_clk      (g_clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .capture    (capture),
        .div_setup  (div_setup),
        .step       (step),
        .op         (op),
        .op_word    (op_word),
        .rs1        (rs1),
        .rs2        (rs2),
        .count      (count),
        .div_result (div_result)
    );

    assign rd = is_mul ? mul_result : div_result;   // Class picks the datapath

    // Both datapaths must be frozen while the FSM holds the result
    rd_stable_in_done_a: assert property (
        @(posedge g_clk) disable iff (!rst_n)
        (state == ST_DONE) && $past(state == ST_DONE) |-> $stable(rd)
    );

endmodule

`default_nettype wire

//--- tb/mdu_clk_gen.sv
/*
 * Testbench clock generator, 20 ns period
 */
`timescale 1ns/1ns
`default_nettype none

module mdu_clk_gen (
    output logic g_clk
);

    initial begin
        g_clk = 1'b0;
    end

    always begin
        #10;                // Half period
        g_clk = ~g_clk;
    end

endmodule

`default_nettype wire

//--- tb/mdu_ref.svh
/*
 * Reference model of the multiply/divide unit
 * Expected rd for every operation by the RISC-V M-extension rules
 */
`ifndef MDU_REF_SVH
`define MDU_REF_SVH

// Operands are widened by one sign bit, so the most negative value
// divided by minus one wraps back onto itself without a special case
function automatic logic [63:0] mdu_ref_result(input mdu_op_e op, input logic word,
                                               input logic [63:0] a, input logic [63:0] b);
    logic signed [129:0] ma;
    logic signed [129:0] mb;
    logic signed [129:0] prod;
    logic signed [64:0]  da;
    logic signed [64:0]  db;
    logic signed [64:0]  q;
    logic signed [64:0]  r;
    logic                a_sgn;
    logic                b_sgn;
    logic [63:0]         res;

    if (op == MDU_MUL || op == MDU_MULH || op == MDU_MULHSU || op == MDU_MULHU) begin
        a_sgn = (op == MDU_MULH) || (op == MDU_MULHSU);   // rs1 signed
        b_sgn = (op == MDU_MULH);                         // rs2 signed
        ma    = a_sgn ? {{66{a[63]}}, a} : {66'd0, a};
        mb    = b_sgn ? {{66{b[63]}}, b} : {66'd0, b};
        prod  = ma * mb;
        if (word) begin
            res = {{32{prod[31]}}, prod[31:0]};   // MULW keeps only the low word
        end else if (op == MDU_MUL) begin
            res = prod[63:0];
        end else begin
            res = prod[127:64];
        end
    end else begin
        a_sgn = (op == MDU_DIV) || (op == MDU_REM);
        b_sgn = a_sgn;
        if (word) begin
            da = a_sgn ? {{33{a[31]}}, a[31:0]} : {33'd0, a[31:0]};
            db = b_sgn ? {{33{b[31]}}, b[31:0]} : {33'd0, b[31:0]};
        end else begin
            da = a_sgn ? {a[63], a} : {1'b0, a};
            db = b_sgn ? {b[63], b} : {1'b0, b};
        end
        if (db == 0) begin
            q = '1;          // Quotient all ones
            r = da;          // Remainder is the dividend
        end else begin
            q = da / db;     // Truncates toward zero
            r = da % db;     // Takes the dividend's sign
        end
        res = (op == MDU_REM || op == MDU_REMU) ? r[63:0] : q[63:0];
        if (word) begin
            res = {{32{res[31]}}, res[31:0]};
        end
    end
    return res;
endfunction

`endif

//--- tb/mdu_tb.sv
/*
 * Testbench top for the multiply/divide unit
 * Corner and random stimulus, comparison process, handshake, latency
 * and flush checks, watchdog and closing report
 */
`timescale 1ns/1ns
`default_nettype none

module mdu_tb
    import mdu_pkg::*;
();

    `include "mdu_ref.svh"

    localparam int RST_CYCLES = 16;
    localparam int N_RAND     = 8;                  // Random pairs per op and width
    localparam int NUM_OPS    = 2*4*16 + 2*2*4*N_RAND + 2*4*2 + 4;
    localparam int WAIT_LIMIT = 2 * XLEN + 8;       // Cycles before giving up on ready

    logic          g_clk;
    logic          rst_n;
    logic          flush;
    logic          valid;
    mdu_op_e       op;
    logic          op_word;
    logic [XL:0]   rs1;
    logic [XL:0]   rs2;
    logic          g_clk_req;
    logic          ready;
    logic [XL:0]   rd;

    integer        seed;
    int            n_errors = 0;
    int            n_checks = 0;
    logic [XL:0]   exp_rd;
    mdu_op_e       cur_op;
    logic          cur_word;
    logic [XL:0]   cur_rs1;
    logic [XL:0]   cur_rs2;
    mdu_op_e       mul_ops [4] = '{MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU};
    mdu_op_e       div_ops [4] = '{MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU};

    mdu_clk_gen mdu_clk_gen_i (
        .g_clk (g_clk)
    );

    mdu_top mdu_top_i (
        .g_clk      (g_clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .valid      (valid),
        .op         (op),
        .op_word    (op_word),
        .rs1        (rs1),
        .rs2        (rs2),
        .g_clk_req  (g_clk_req),
        .ready      (ready),
        .rd         (rd)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic logic [XL:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // 0, 1, all ones, most negative value of the chosen width
    function automatic logic [XL:0] corner_value(input int idx, input logic w);
        case (idx)
            0:       return '0;
            1:       return XLEN'(1);
            2:       return '1;
            default: return w ? {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}}
                              : {1'b1, {XL{1'b0}}};
        endcase
    endfunction

    // Capture edge counts as the first cycle
    function automatic int expected_latency(input mdu_op_e o, input logic w);
        int n;
        n = w ? WLEN : XLEN;
        if (o == MDU_MUL || o == MDU_MULH || o == MDU_MULHSU || o == MDU_MULHU) begin
            return n / MUL_UNROLL + 1;
        end
        return n + 3;
    endfunction

    // Issue one operation, check latency, hold and release
    task automatic run_op(input mdu_op_e o, input logic w, input logic [XL:0] a,
                          input logic [XL:0] b, input int hold);
        int          lat;
        int          exp_lat;
        logic [XL:0] held;
        exp_rd   = mdu_ref_result(o, w, a, b);
        exp_lat  = expected_latency(o, w);
        cur_op   = o;
        cur_word = w;
        cur_rs1  = a;
        cur_rs2  = b;
        @(posedge g_clk);
        op      <= o;
        op_word <= w;
        rs1     <= a;
        rs2     <= b;
        valid   <= 1'b1;
        @(posedge g_clk);                       // Capture edge
        lat = 1;
        @(negedge g_clk);
        while (ready !== 1'b1 && lat < WAIT_LIMIT) begin
            @(posedge g_clk);
            lat++;
            @(negedge g_clk);
        end
        if (ready !== 1'b1) begin
            $display("ready never rose for op 0x%h word %0d", o, w);
            n_errors++;
        end else begin
            if (lat != exp_lat) begin
                $display("ready rose after %0d cycles instead of %0d for op 0x%h word %0d",
                         lat, exp_lat, o, w);
                n_errors++;
            end
            held = rd;
            repeat (hold) begin
                @(posedge g_clk);
                @(negedge g_clk);
                if (ready !== 1'b1) begin
                    $display("Error ready 0x%h expected 0x1 while valid held", ready);
                    n_errors++;
                end
                if (rd !== held) begin
                    $display("Error rd 0x%h expected 0x%h while valid held", rd, held);
                    n_errors++;
                end
            end
        end
        @(posedge g_clk);
        valid <= 1'b0;
        @(posedge g_clk);
        @(negedge g_clk);
        if (ready !== 1'b0) begin
            $display("Error ready 0x%h expected 0x0 after valid fell", ready);
            n_errors++;
        end
    endtask

    // Start an operation and flush it after a number of cycles
    task automatic flush_op(input mdu_op_e o, input logic w, input logic [XL:0] a,
                            input logic [XL:0] b, input int after);
        int win;
        win = after + expected_latency(o, w) + 4;   // Past the normal completion
        @(posedge g_clk);
        op      <= o;
        op_word <= w;
        rs1     <= a;
        rs2     <= b;
        valid   <= 1'b1;
        for (int i = 0; i < win; i++) begin
            @(posedge g_clk);
            if (i == after) begin
                flush <= 1'b1;
                valid <= 1'b0;
            end else if (i == after + 1) begin
                flush <= 1'b0;
            end
            @(negedge g_clk);
            if (ready !== 1'b0) begin
                $display("Error ready 0x%h expected 0x0 around flush", ready);
                n_errors++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Comparison process
    // ------------------------------------------------------------------------

    initial begin : compare
        logic ready_q;
        ready_q = 1'b0;
        @(posedge g_clk);
        forever begin
            @(negedge g_clk);
            if (ready === 1'b1 && !ready_q) begin     // First cycle of ready
                n_checks++;
                if (rd !== exp_rd) begin
                    $display("Error rd 0x%h expected 0x%h op 0x%h word 0x%h rs1 0x%h rs2 0x%h",
                             rd, exp_rd, cur_op, cur_word, cur_rs1, cur_rs2);
                    n_errors++;
                end
            end
            if (g_clk_req !== (valid | flush)) begin
                $display("Error g_clk_req 0x%h expected 0x%h", g_clk_req, valid | flush);
                n_errors++;
            end
            ready_q = (ready === 1'b1);
        end
    end

    // Watchdog allows 80 cycles per operation plus reset
    initial begin : watchdog
        repeat (RST_CYCLES + NUM_OPS * 80) @(posedge g_clk);
        $display("Timeout: the unit stopped answering before all operations finished");
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin : stimulus
        logic [XL:0] b;
        seed    = 32'h13fb;
        rst_n   = 1'b0;
        flush   = 1'b0;
        valid   = 1'b0;
        op      = MDU_MUL;
        op_word = 1'b0;
        rs1     = '0;
        rs2     = '0;

        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge g_clk);
            if (i == RST_CYCLES - 1) begin
                rst_n <= 1'b1;
            end
            @(negedge g_clk);
            if (ready !== 1'b0) begin
                $display("Error ready 0x%h expected 0x0 during reset", ready);
                n_errors++;
            end
        end

        // Multiply corners
        for (int w = 0; w < 2; w++) begin
            for (int o = 0; o < 4; o++) begin
                for (int i = 0; i < 4; i++) begin
                    for (int j = 0; j < 4; j++) begin
                        run_op(mul_ops[o], w != 0, corner_value(i, w != 0),
                               corner_value(j, w != 0), 0);
                    end
                end
            end
        end

        // Random multiply and divide with divisors of varied size
        for (int w = 0; w < 2; w++) begin
            for (int o = 0; o < 4; o++) begin
                repeat (N_RAND) run_op(mul_ops[o], w != 0, rand64(), rand64(), 2);
                repeat (N_RAND) begin
                    b = rand64() >> ($unsigned($random(seed)) % XLEN);
                    run_op(div_ops[o], w != 0, rand64(), b, 1);
                end
            end
        end

        // Division by zero and signed overflow
        for (int w = 0; w < 2; w++) begin
            for (int o = 0; o < 4; o++) begin
                run_op(div_ops[o], w != 0, rand64(), '0, 0);
                run_op(div_ops[o], w != 0, corner_value(3, w != 0), '1, 0);
            end
        end

        // Flush mid-run and then the same operation again
        flush_op(MDU_MULH, 1'b0, 64'h8765_4321_0fed_cba9, 64'hfedc_ba98_7654_3210, 5);
        run_op(MDU_MULH, 1'b0, 64'h8765_4321_0fed_cba9, 64'hfedc_ba98_7654_3210, 0);
        flush_op(MDU_REM, 1'b1, 64'h0000_0000_9abc_def0, 64'h0000_0000_0000_1234, 12);
        run_op(MDU_REM, 1'b1, 64'h0000_0000_9abc_def0, 64'h0000_0000_0000_1234, 0);

        $display("Checked %0d results, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
